/* logic/spi_bridge_pkg.sv */
//////////////////////////////
// spi bridge shared definitions
// bus widths, host register map and frame constants
//////////////////////////////

`default_nettype none

package spi_bridge_pkg;

  // register bus and spi data word width
  localparam int DATA_W = 32;

  // spi target address width
  localparam int SPI_ADDR_W = 10;

  // word count width
  localparam int LEN_W = 8;

  // spi clock divide factor width
  localparam int DIV_W = 5;

  // host register address width
  localparam int REG_ADDR_W = 3;

  // header is one direction bit followed by the target address
  localparam int HDR_BITS = 1 + SPI_ADDR_W;

  // host register map, doubles as the bridge opcode set
  typedef enum logic [REG_ADDR_W-1:0] {
    REG_WNR        = 3'd0,  // bit 0 set selects a write frame
    REG_ADDRESS    = 3'd1,
    REG_DATA_LEN   = 3'd2,  // nonzero write starts a frame
    REG_WRITE_DATA = 3'd3,  // pushes the command FIFO
    REG_READ_DATA  = 3'd4,  // read pops the read FIFO
    REG_CLK_DIV    = 3'd5,
    REG_DONE       = 3'd6   // read only
  } reg_addr_e;

  // frame sequencer states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_HEADER,
    ST_DATA,
    ST_FINISH
  } frame_state_e;

endpackage

`default_nettype wire

/* logic/spi_bridge_top.sv */
//////////////////////////////
// spi master bridge top
// controller, FIFOs, divider and sequencer
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_bridge_top #(
  parameter int DATA_WIDTH = spi_bridge_pkg::DATA_W,
  parameter int FIFO_DEPTH = 10
) (
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  input  logic                                  reg_wr_en,
  input  logic                                  reg_rd_en,
  input  logic [spi_bridge_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [DATA_WIDTH-1:0]                 reg_wdata,
  output logic [DATA_WIDTH-1:0]                 reg_rdata,
  input  logic                                  poci,
  output logic                                  pico,
  output logic                                  cs_b,
  output logic                                  spi_clk
);

  import spi_bridge_pkg::*;

  // host side FIFO strobes
  logic                  cmd_push;
  logic [DATA_WIDTH-1:0] cmd_wdata;
  logic                  cmd_full;
  logic                  rd_pop;
  logic [DATA_WIDTH-1:0] rd_head;
  logic                  rd_empty;
  // sequencer side FIFO strobes
  logic                  cmd_pop;
  logic [DATA_WIDTH-1:0] cmd_head;
  logic                  cmd_empty;
  logic                  rd_push;
  logic [DATA_WIDTH-1:0] rd_wdata;
  // latched frame setup
  logic                  frame_start;
  logic                  frame_done;
  logic                  wnr;
  logic [SPI_ADDR_W-1:0] spi_addr;
  logic [LEN_W-1:0]      word_len;
  // spi clock control
  logic [DIV_W-1:0]      clk_div;
  logic                  div_reset;
  logic                  clk_en;
  logic                  tick_rise;
  logic                  tick_fall;

  spi_reg_ctrl #(.DATA_WIDTH(DATA_WIDTH)) u_reg_ctrl (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .reg_wr_en(reg_wr_en), .reg_rd_en(reg_rd_en), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .cmd_full(cmd_full), .rd_empty(rd_empty),
    .rd_head(rd_head), .frame_done(frame_done), .reg_rdata(reg_rdata),
    .cmd_push(cmd_push), .cmd_wdata(cmd_wdata), .rd_pop(rd_pop),
    .frame_start(frame_start), .wnr(wnr), .spi_addr(spi_addr),
    .word_len(word_len), .clk_div(clk_div), .div_reset(div_reset)
  );

  // words to send
  sync_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) cmd_fifo (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .push(cmd_push), .wdata(cmd_wdata), .pop(cmd_pop),
    .rdata(cmd_head), .full(cmd_full), .empty(cmd_empty)
  );

  // words received, full only drops pushes so the flag stays open
  sync_fifo #(.DATA_WIDTH(DATA_WIDTH), .FIFO_DEPTH(FIFO_DEPTH)) rd_fifo (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .push(rd_push), .wdata(rd_wdata), .pop(rd_pop),
    .rdata(rd_head), .full(), .empty(rd_empty)
  );

  spi_clk_gen u_clk_gen (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .enable(clk_en), .div_reset(div_reset), .clk_div(clk_div),
    .spi_clk(spi_clk), .tick_rise(tick_rise), .tick_fall(tick_fall)
  );

  // frame_state_e lives in here for waveform debug
  spi_frame_seq #(.DATA_WIDTH(DATA_WIDTH)) u_frame_seq (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .frame_start(frame_start), .wnr(wnr), .spi_addr(spi_addr),
    .word_len(word_len), .tick_rise(tick_rise), .tick_fall(tick_fall),
    .cmd_head(cmd_head), .cmd_empty(cmd_empty), .poci(poci),
    .clk_en(clk_en), .cs_b(cs_b), .pico(pico), .cmd_pop(cmd_pop),
    .rd_push(rd_push), .rd_wdata(rd_wdata), .frame_done(frame_done)
  );

endmodule

`default_nettype wire

/* logic/spi_clk_gen.sv */
//////////////////////////////
// spi clock divider
// divided spi_clk with edge ticks
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_clk_gen (
  input  logic                           S_AXI_ACLK,
  input  logic                           S_AXI_ARESETN,
  input  logic                           enable,
  input  logic                           div_reset,
  input  logic [spi_bridge_pkg::DIV_W-1:0] clk_div,
  output logic                           spi_clk,
  output logic                           tick_rise,
  output logic                           tick_fall
);

  import spi_bridge_pkg::*;

  // half period counter, wraps at clk_div
  logic [DIV_W-1:0] cnt;

  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      cnt       <= '0;
      spi_clk   <= 1'b0;
      tick_rise <= 1'b0;
      tick_fall <= 1'b0;
    end else begin
      // ticks are single cycle
      tick_rise <= 1'b0;
      tick_fall <= 1'b0;
      if (!enable || div_reset) begin
        // park low, next enable starts a full half period
        cnt     <= '0;
        spi_clk <= 1'b0;
      end else if (cnt == clk_div) begin
        cnt     <= '0;
        spi_clk <= ~spi_clk;
        // tick lines up with the new spi_clk level
        tick_rise <= ~spi_clk;
        tick_fall <= spi_clk;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/spi_frame_seq.sv */
//////////////////////////////
// spi frame sequencer
// shifts header, then counted data words
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_frame_seq #(
  parameter int DATA_WIDTH = spi_bridge_pkg::DATA_W
) (
  input  logic                                S_AXI_ACLK,
  input  logic                                S_AXI_ARESETN,
  input  logic                                frame_start,
  input  logic                                wnr,
  input  logic [spi_bridge_pkg::SPI_ADDR_W-1:0] spi_addr,
  input  logic [spi_bridge_pkg::LEN_W-1:0]    word_len,
  input  logic                                tick_rise,
  input  logic                                tick_fall,
  input  logic [DATA_WIDTH-1:0]               cmd_head,
  input  logic                                cmd_empty,
  input  logic                                poci,
  output logic                                clk_en,
  output logic                                cs_b,
  output logic                                pico,
  output logic                                cmd_pop,
  output logic                                rd_push,
  output logic [DATA_WIDTH-1:0]               rd_wdata,
  output logic                                frame_done
);

  import spi_bridge_pkg::*;

  localparam int BIT_W = $clog2(DATA_WIDTH);

  frame_state_e          state;
  // bits left in the current field after the next rising tick
  logic [BIT_W-1:0]      bit_cnt;
  logic [LEN_W-1:0]      word_cnt;
  // next falling tick loads a fresh word instead of shifting
  logic                  load_word;
  logic [DATA_WIDTH-1:0] tx_sh;
  logic [DATA_WIDTH-1:0] rx_sh;

  // msb first out of the transmit shifter
  assign pico = tx_sh[DATA_WIDTH-1];

  // after the last data bit the receive shifter holds the whole word
  assign rd_wdata = rx_sh;

  // receive shifter samples poci on rising ticks
  always_ff @(posedge S_AXI_ACLK) begin
    if (tick_rise && (state == ST_HEADER || state == ST_DATA)) begin
      rx_sh <= {rx_sh[DATA_WIDTH-2:0], poci};
    end
  end

  //////////////////////////////
  // frame FSM
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      state      <= ST_IDLE;
      clk_en     <= 1'b0;
      cs_b       <= 1'b1;
      tx_sh      <= '0;
      bit_cnt    <= '0;
      word_cnt   <= '0;
      load_word  <= 1'b0;
      cmd_pop    <= 1'b0;
      rd_push    <= 1'b0;
      frame_done <= 1'b0;
    end else begin
      cmd_pop    <= 1'b0;
      rd_push    <= 1'b0;
      frame_done <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (frame_start) begin
            // direction bit sits on pico before the first rising edge
            tx_sh     <= {wnr, spi_addr, {(DATA_WIDTH - HDR_BITS){1'b0}}};
            bit_cnt   <= BIT_W'(HDR_BITS - 1);
            word_cnt  <= word_len;
            load_word <= 1'b0;
            cs_b      <= 1'b0;
            clk_en    <= 1'b1;
            state     <= ST_HEADER;
          end
        end
        ST_HEADER: begin
          if (tick_fall) begin
            tx_sh <= tx_sh << 1;
          end
          if (tick_rise) begin
            if (bit_cnt == '0) begin
              // header done, first word goes out on the next fall
              bit_cnt   <= BIT_W'(DATA_WIDTH - 1);
              load_word <= 1'b1;
              state     <= ST_DATA;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        ST_DATA: begin
          if (tick_fall) begin
            if (load_word) begin
              load_word <= 1'b0;
              // write frame with an empty FIFO sends zeros
              if (wnr && !cmd_empty) begin
                tx_sh   <= cmd_head;
                cmd_pop <= 1'b1;
              end else begin
                tx_sh <= '0;
              end
            end else begin
              tx_sh <= tx_sh << 1;
            end
          end
          if (tick_rise) begin
            if (bit_cnt == '0) begin
              // word complete, read frames push it (dropped by a full FIFO)
              rd_push <= !wnr;
              if (word_cnt == LEN_W'(1)) begin
                clk_en <= 1'b0;
                cs_b   <= 1'b1;
                tx_sh  <= '0;
                state  <= ST_FINISH;
              end else begin
                word_cnt  <= word_cnt - 1'b1;
                bit_cnt   <= BIT_W'(DATA_WIDTH - 1);
                load_word <= 1'b1;
              end
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
            end
          end
        end
        ST_FINISH: begin
          // one cycle after cs_b rises
          frame_done <= 1'b1;
          state      <= ST_IDLE;
        end
        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/spi_reg_ctrl.sv */
//////////////////////////////
// spi bridge register controller
// host registers, busy/done tracking, FIFO strobes
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_reg_ctrl #(
  parameter int DATA_WIDTH = spi_bridge_pkg::DATA_W
) (
  input  logic                                  S_AXI_ACLK,
  input  logic                                  S_AXI_ARESETN,
  input  logic                                  reg_wr_en,
  input  logic                                  reg_rd_en,
  input  logic [spi_bridge_pkg::REG_ADDR_W-1:0] reg_addr,
  input  logic [DATA_WIDTH-1:0]                 reg_wdata,
  input  logic                                  cmd_full,
  input  logic                                  rd_empty,
  input  logic [DATA_WIDTH-1:0]                 rd_head,
  input  logic                                  frame_done,
  output logic [DATA_WIDTH-1:0]                 reg_rdata,
  output logic                                  cmd_push,
  output logic [DATA_WIDTH-1:0]                 cmd_wdata,
  output logic                                  rd_pop,
  output logic                                  frame_start,
  output logic                                  wnr,
  output logic [spi_bridge_pkg::SPI_ADDR_W-1:0] spi_addr,
  output logic [spi_bridge_pkg::LEN_W-1:0]      word_len,
  output logic [spi_bridge_pkg::DIV_W-1:0]      clk_div,
  output logic                                  div_reset
);

  import spi_bridge_pkg::*;

  reg_addr_e         addr;
  // host visible registers
  logic              wnr_reg;
  logic [SPI_ADDR_W-1:0] addr_reg;
  logic [LEN_W-1:0]  len_reg;
  // last written factor, may wait for frame end
  logic [DIV_W-1:0]  div_reg;
  logic              busy;
  logic              done;
  logic [LEN_W-1:0]  wr_len;

  assign addr   = reg_addr_e'(reg_addr);
  assign wr_len = reg_wdata[LEN_W-1:0];

  // command words go straight into the FIFO, dropped when full
  assign cmd_push  = reg_wr_en && (addr == REG_WRITE_DATA) && !cmd_full;
  assign cmd_wdata = reg_wdata;

  // pop only between frames, the sequencer may still be filling
  assign rd_pop = reg_rd_en && (addr == REG_READ_DATA) && !busy && !rd_empty;

  //////////////////////////////
  // register writes and frame control
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wnr_reg     <= 1'b0;
      addr_reg    <= '0;
      len_reg     <= '0;
      div_reg     <= '0;
      wnr         <= 1'b0;
      spi_addr    <= '0;
      word_len    <= '0;
      clk_div     <= '0;
      busy        <= 1'b0;
      done        <= 1'b0;
      frame_start <= 1'b0;
      div_reset   <= 1'b0;
    end else begin
      frame_start <= 1'b0;
      div_reset   <= 1'b0;
      // frame end: flag done, clear count, apply a held factor
      if (busy && frame_done) begin
        busy    <= 1'b0;
        done    <= 1'b1;
        len_reg <= '0;
        if (div_reg != clk_div) begin
          clk_div   <= div_reg;
          div_reset <= 1'b1;
        end
      end
      if (reg_wr_en) begin
        case (addr)
          REG_WNR: wnr_reg <= reg_wdata[0];
          REG_ADDRESS: addr_reg <= reg_wdata[SPI_ADDR_W-1:0];
          REG_DATA_LEN: begin
            len_reg <= wr_len;
            // nonzero count while idle launches a frame
            if (!busy && wr_len != '0) begin
              busy        <= 1'b1;
              done        <= 1'b0;
              frame_start <= 1'b1;
              wnr         <= wnr_reg;
              spi_addr    <= addr_reg;
              word_len    <= wr_len;
            end
          end
          REG_CLK_DIV: begin
            div_reg <= reg_wdata[DIV_W-1:0];
            // idle write takes effect now and restarts the divider
            if (!busy) begin
              clk_div   <= reg_wdata[DIV_W-1:0];
              div_reset <= 1'b1;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  //////////////////////////////
  // registered read mux
  //////////////////////////////
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      reg_rdata <= '0;
    end else if (reg_rd_en) begin
      case (addr)
        REG_WNR:       reg_rdata <= DATA_WIDTH'(wnr_reg);
        REG_ADDRESS:   reg_rdata <= DATA_WIDTH'(addr_reg);
        REG_DATA_LEN:  reg_rdata <= DATA_WIDTH'(len_reg);
        // head at the strobe, zero once drained
        REG_READ_DATA: reg_rdata <= rd_empty ? '0 : rd_head;
        REG_CLK_DIV:   reg_rdata <= DATA_WIDTH'(div_reg);
        REG_DONE:      reg_rdata <= DATA_WIDTH'(done);
        // write data register and unmapped slots read zero
        default:       reg_rdata <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

/* logic/sync_fifo.sv */
//////////////////////////////
// single clock show-ahead FIFO
// circular buffer, any depth
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int DATA_WIDTH = 32,
  parameter int FIFO_DEPTH = 10
) (
  input  logic                  S_AXI_ACLK,
  input  logic                  S_AXI_ARESETN,
  input  logic                  push,
  input  logic [DATA_WIDTH-1:0] wdata,
  input  logic                  pop,
  output logic [DATA_WIDTH-1:0] rdata,
  output logic                  full,
  output logic                  empty
);

  // pointer and occupancy widths
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;
  logic                  do_push;
  logic                  do_pop;

  // push ignored when full, pop ignored when empty
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

  // head always visible
  assign rdata = mem[rd_ptr];

  // storage
  always_ff @(posedge S_AXI_ACLK) begin
    if (do_push) begin
      mem[wr_ptr] <= wdata;
    end
  end

  // pointers wrap at depth, not at a power of two
  always_ff @(posedge S_AXI_ACLK) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // occupancy holds when both happen together
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* spi_bridge.f */
logic/spi_bridge_pkg.sv
logic/sync_fifo.sv
logic/spi_clk_gen.sv
logic/spi_frame_seq.sv
logic/spi_reg_ctrl.sv
logic/spi_bridge_top.sv
verif/spi_periph_model.sv
verif/tb_spi_bridge.sv

/* verif/spi_bridge_patterns.txt */
# op addr value, hex. W writes a register, R reads and expects the value,
# F waits for done and expects that frame's spi_clk half period in cycles
R 0 00000000
R 1 00000000
R 2 00000000
R 3 00000000
R 4 00000000
R 5 00000000
R 6 00000000
R 7 00000000
W 0 ffffffff
R 0 00000001
W 1 fffff123
R 1 00000123
W 5 ffffffe3
R 5 00000003
# write frame, three words to 0x123
W 3 a5a50001
W 3 5a5a0002
W 3 0f0f0003
R 3 00000000
W 2 00000003
F 0 00000004
R 6 00000001
R 2 00000000
# read frame back, divider changed while busy
W 0 00000000
W 2 00000003
W 5 00000001
R 2 00000003
R 5 00000001
F 0 00000004
R 6 00000001
R 4 a5a50001
R 4 5a5a0002
R 4 0f0f0003
R 4 00000000
# one word read at the new divider
W 2 00000001
F 0 00000002
R 2 00000000
R 4 a5a50001
R 4 00000000

/* verif/spi_periph_model.sv */
//////////////////////////////
// spi peripheral model
// header decode over a 1024 word memory
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module spi_periph_model (
  input  logic spi_clk,
  input  logic cs_b,
  input  logic pico,
  output logic poci
);

  logic [31:0] mem [1024];
  // direction bit then ten address bits
  logic [10:0] hdr;
  logic [31:0] rx_word;
  logic [31:0] tx_word;
  logic        wr_frame;
  logic [9:0]  base;
  logic [9:0]  word_idx;
  int          bit_idx;

  initial begin
    poci     = 1'b0;
    hdr      = '0;
    rx_word  = '0;
    tx_word  = '0;
    wr_frame = 1'b0;
    base     = '0;
    word_idx = '0;
    bit_idx  = 0;
    for (int i = 0; i < 1024; i++) begin
      mem[i] = '0;
    end
  end

  // new frame
  always @(negedge cs_b) begin
    bit_idx  = 0;
    word_idx = '0;
  end

  // sample pico on rising spi_clk, msb first
  always @(posedge spi_clk) begin
    if (!cs_b) begin
      if (bit_idx < 11) begin
        hdr = {hdr[9:0], pico};
      end else begin
        rx_word = {rx_word[30:0], pico};
      end
      bit_idx = bit_idx + 1;
      if (bit_idx == 11) begin
        wr_frame = hdr[10];
        base     = hdr[9:0];
        tx_word  = mem[base];
      end else if (bit_idx > 11 && (bit_idx - 11) % 32 == 0) begin
        // word boundary, address wraps at ten bits
        if (wr_frame) begin
          mem[base + word_idx] = rx_word;
        end
        word_idx = word_idx + 1'b1;
        tx_word  = mem[base + word_idx];
      end
    end
  end

  // poci changes on falling spi_clk once the header is in
  always @(negedge spi_clk) begin
    if (!cs_b && bit_idx >= 11) begin
      poci    = tx_word[31];
      tx_word = tx_word << 1;
    end
  end

endmodule

`default_nettype wire

/* verif/tb_spi_bridge.sv */
//////////////////////////////
// spi bridge testbench
// pattern driven host ops against a peripheral model
//////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_spi_bridge;

  import spi_bridge_pkg::*;

  logic                  S_AXI_ACLK;
  logic                  S_AXI_ARESETN;
  logic                  reg_wr_en;
  logic                  reg_rd_en;
  logic [REG_ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0]     reg_wdata;
  logic [DATA_W-1:0]     reg_rdata;
  logic                  poci;
  logic                  pico;
  logic                  cs_b;
  logic                  spi_clk;

  // pattern table, one entry per file line
  byte         pat_op [$];
  logic [31:0] pat_addr [$];
  logic [31:0] pat_val [$];
  logic        open_failed = 1'b0;

  int          cycle_cnt = 0;
  int          cycle_limit = 0;
  int          check_cnt = 0;
  int          err_cnt = 0;
  int          test_cnt = 0;
  int          errs_before;
  logic [31:0] rd_val;
  logic        waiting_done = 1'b0;
  // first spi_clk high phase of the current frame, in ACLK cycles
  int          hi_cnt = 0;
  int          half_meas = 0;
  logic        half_seen = 1'b0;

  spi_bridge_top #(.DATA_WIDTH(DATA_W), .FIFO_DEPTH(10)) uut (
    .S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
    .reg_wr_en(reg_wr_en), .reg_rd_en(reg_rd_en), .reg_addr(reg_addr),
    .reg_wdata(reg_wdata), .reg_rdata(reg_rdata), .poci(poci),
    .pico(pico), .cs_b(cs_b), .spi_clk(spi_clk)
  );

  spi_periph_model u_periph (
    .spi_clk(spi_clk), .cs_b(cs_b), .pico(pico), .poci(poci)
  );

  // 20 ns ACLK
  initial begin
    S_AXI_ACLK = 1'b0;
    forever #10 S_AXI_ACLK = ~S_AXI_ACLK;
  end

  // watchdog
  always @(posedge S_AXI_ACLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
      if (waiting_done) begin
        $display("timeout: the SPI frame never finished within %0d cycles", cycle_limit);
      end else begin
        $display("timeout: the run went past %0d cycles", cycle_limit);
      end
      $display("Checks failed");
      $finish;
    end
  end

  // measured away from the active edge
  always @(negedge S_AXI_ACLK) begin
    if (cs_b) begin
      hi_cnt    <= 0;
      half_seen <= 1'b0;
    end else if (spi_clk) begin
      hi_cnt <= hi_cnt + 1;
    end else if (hi_cnt == 0) begin
      // cleared at the start of each frame
      half_meas <= 0;
    end else if (!half_seen) begin
      half_meas <= hi_cnt;
      half_seen <= 1'b1;
    end
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_test(input string name, input int errs);
    test_cnt++;
    if (err_cnt == errs) begin
      $display("test %0d %s: pass", test_cnt, name);
    end else begin
      $display("test %0d %s: fail", test_cnt, name);
    end
  endtask

  // one cycle write strobe, sampled on the following edge
  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    @(posedge S_AXI_ACLK);
    #2;
    reg_wr_en = 1'b1;
    reg_addr  = addr[REG_ADDR_W-1:0];
    reg_wdata = data;
    @(posedge S_AXI_ACLK);
    #2;
    reg_wr_en = 1'b0;
  endtask

  // rdata is registered, valid after the strobe edge
  task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
    @(posedge S_AXI_ACLK);
    #2;
    reg_rd_en = 1'b1;
    reg_addr  = addr[REG_ADDR_W-1:0];
    @(posedge S_AXI_ACLK);
    #2;
    reg_rd_en = 1'b0;
    data      = reg_rdata;
  endtask

  // poll the done register, watchdog bounds the loop
  task automatic wait_frame_done();
    logic [31:0] d;
    waiting_done = 1'b1;
    d = '0;
    while (d[0] !== 1'b1) begin
      read_reg(32'(REG_DONE), d);
    end
    waiting_done = 1'b0;
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    byte         op;
    logic [31:0] a;
    logic [31:0] v;
    int          div;
    fd = $fopen("verif/spi_bridge_patterns.txt", "r");
    if (fd == 0) begin
      open_failed = 1'b1;
    end else begin
      div = 0;
      cycle_limit = 2000;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        n = 0;
        if (line.len() > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%c %h %h", op, a, v);
        end
        if (n == 3) begin
          pat_op.push_back(op);
          pat_addr.push_back(a);
          pat_val.push_back(v);
          // factor in force when the frame starts
          if (op == "W" && a == 5) begin
            div = int'(v[4:0]);
          end
          // 11 header bits plus 32 per word, two half periods each
          if (op == "W" && a == 2 && v[7:0] != 0) begin
            cycle_limit += (11 + 32 * int'(v[7:0])) * 2 * (div + 1);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////
  initial begin
    S_AXI_ARESETN = 1'b0;
    reg_wr_en     = 1'b0;
    reg_rd_en     = 1'b0;
    reg_addr      = '0;
    reg_wdata     = '0;
    load_patterns();
    if (open_failed) begin
      $display("could not open the pattern file verif/spi_bridge_patterns.txt");
      $display("Checks failed");
      $finish;
    end else begin
      repeat (5) @(posedge S_AXI_ACLK);
      #2;
      S_AXI_ARESETN = 1'b1;
      @(posedge S_AXI_ACLK);
      #2;
      errs_before = err_cnt;
      check_value(32'(cs_b), 32'd1, "cs_b after reset");
      check_value(32'(spi_clk), 32'd0, "spi_clk after reset");
      check_value(32'(pico), 32'd0, "pico after reset");
      finish_test("reset pin levels", errs_before);
      for (int i = 0; i < pat_op.size(); i++) begin
        errs_before = err_cnt;
        case (pat_op[i])
          "W": begin
            write_reg(pat_addr[i], pat_val[i]);
          end
          "R": begin
            read_reg(pat_addr[i], rd_val);
            check_value(rd_val, pat_val[i], $sformatf("register %0d", pat_addr[i]));
            finish_test($sformatf("read register %0d", pat_addr[i]), errs_before);
          end
          "F": begin
            wait_frame_done();
            // value column holds the expected half period
            check_value(32'(half_meas), pat_val[i], "spi_clk half period");
            finish_test("frame done", errs_before);
          end
          default: begin
            err_cnt++;
            $display("pattern entry %0d has an unknown operation", i);
          end
        endcase
      end
      $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("All checks passed");
      end else begin
        $display("Checks failed");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
